/* hdl/cpuPkg.sv */
package cpuPkg;

	// Datapath and storage sizes
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 4;
	localparam int imemAddrWidth = 8;
	localparam int dmemAddrWidth = 8;

	// NVZ flag register layout
	localparam int flagWidth = 3;
	localparam int flagN = 2;
	localparam int flagV = 1;
	localparam int flagZ = 0;

	// Opcode sits in bits 15..12 and any code not listed runs as a NOP
	// Register ops take rd in 11..8, rs in 7..4 and rt in 3..0 while shifts read 3..0 as the amount
	// and lw or sw use data reg 11..8, base 7..4 and a signed word offset in 3..0 while llb or lhb
	// put rd in 11..8 and the byte in 7..0 and a branch keeps its condition in 11..9 and a
	// signed 9-bit offset from PC+1
	typedef enum logic [3:0] {
		OpAdd = 4'h0,
		OpSub = 4'h1,
		OpXor = 4'h2,
		OpAnd = 4'h3,
		OpOr  = 4'h4,
		OpSll = 4'h5,
		OpSra = 4'h6,
		OpLw  = 4'h7,
		OpSw  = 4'h8,
		OpLlb = 4'h9,
		OpLhb = 4'hA,
		OpB   = 4'hB,
		OpHlt = 4'hF
	} opcodeT;

	// Branch conditions in bits 11..9
	typedef enum logic [2:0] {
		CondNe = 3'd0,
		CondEq = 3'd1,
		CondGt = 3'd2,
		CondLt = 3'd3,
		CondGe = 3'd4,
		CondLe = 3'd5,
		CondOv = 3'd6,
		CondAl = 3'd7
	} condT;

	// Operand source selects for execute
	localparam logic [1:0] fwdReg = 2'b00;
	localparam logic [1:0] fwdWb = 2'b01;
	localparam logic [1:0] fwdMem = 2'b10;

	// Bubble word, opcode 0xC
	localparam logic [dataWidth-1:0] nopInstr = 16'hC000;

	// First register operand, zero when the instruction reads none
	function automatic logic [regAddrWidth-1:0] regSrcA(input logic [dataWidth-1:0] instr);
		logic [regAddrWidth-1:0] src;
		case (opcodeT'(instr[15:12]))
			OpAdd, OpSub, OpXor, OpAnd, OpOr, OpSll, OpSra, OpLw, OpSw: src = instr[7:4];
			default: src = '0;
		endcase
		return src;
	endfunction

	// Second register operand
	// Store and byte loads read their rd field here
	function automatic logic [regAddrWidth-1:0] regSrcB(input logic [dataWidth-1:0] instr);
		logic [regAddrWidth-1:0] src;
		case (opcodeT'(instr[15:12]))
			OpAdd, OpSub, OpXor, OpAnd, OpOr: src = instr[3:0];
			OpSw, OpLlb, OpLhb: src = instr[11:8];
			default: src = '0;
		endcase
		return src;
	endfunction

endpackage

/* hdl/fetch.sv */
`timescale 1ns/1ns

module fetch (
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic halted,
	input  logic branchTaken,
	input  logic [cpuPkg::imemAddrWidth-1:0] branchTarget,
	input  logic imemWe,
	input  logic [cpuPkg::imemAddrWidth-1:0] imemAddr,
	input  logic [cpuPkg::dataWidth-1:0] imemData,
	output logic [cpuPkg::imemAddrWidth-1:0] pc,
	output logic [cpuPkg::imemAddrWidth-1:0] pcNextIf,
	output logic [cpuPkg::dataWidth-1:0] instrIf
);
	import cpuPkg::*;

	// Instruction words, one per PC value
	logic [dataWidth-1:0] imem [0:(1 << imemAddrWidth)-1];

	// Program load port
	// Only driven while the core sits in reset
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	// Asynchronous read at the current PC
	assign instrIf = imem[pc];

	// Word-addressed, so the next PC is one up
	assign pcNextIf = pc + 1'b1;

	// Halt freezes everything
	// Stall wins over a redirect since the branch is re-evaluated next cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (halted || stall) begin
			pc <= pc;
		end else if (branchTaken) begin
			pc <= branchTarget;
		end else begin
			pc <= pcNextIf;
		end
	end

endmodule

/* hdl/decode.sv */
`timescale 1ns/1ns

module decode (
	input  logic clk,
	input  logic rst,
	input  logic [cpuPkg::dataWidth-1:0] instrId,
	input  logic [cpuPkg::imemAddrWidth-1:0] pcNextId,
	input  logic regWriteWb,
	input  logic [cpuPkg::regAddrWidth-1:0] rdWb,
	input  logic [cpuPkg::dataWidth-1:0] writeDataWb,
	input  logic [cpuPkg::flagWidth-1:0] flagsNext,
	input  logic [cpuPkg::flagWidth-1:0] flagsWe,
	output logic [cpuPkg::regAddrWidth-1:0] rsId,
	output logic [cpuPkg::regAddrWidth-1:0] rtId,
	output logic [cpuPkg::dataWidth-1:0] regDataA,
	output logic [cpuPkg::dataWidth-1:0] regDataB,
	output cpuPkg::opcodeT op,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic setsFlags,
	output logic branchTaken,
	output logic [cpuPkg::imemAddrWidth-1:0] branchTarget,
	output logic isHalt
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regFile [0:(1 << regAddrWidth)-1];
	logic [flagWidth-1:0] flags;
	logic condTrue;
	logic [dataWidth-1:0] offsetExt;
	logic [dataWidth-1:0] targetFull;

	assign op = opcodeT'(instrId[15:12]);
	assign rsId = regSrcA(instrId);
	assign rtId = regSrcB(instrId);

	// Control bits per opcode
	always_comb begin
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		setsFlags = 1'b0;
		isHalt = 1'b0;
		case (op)
			OpAdd, OpSub, OpXor, OpAnd, OpOr, OpSll, OpSra: begin
				regWrite = 1'b1;
				setsFlags = 1'b1;
			end
			OpLw: begin
				regWrite = 1'b1;
				memRead = 1'b1;
			end
			OpSw: memWrite = 1'b1;
			OpLlb, OpLhb: regWrite = 1'b1;
			OpHlt: isHalt = 1'b1;
			default: ;
		endcase
	end

	// Writeback port
	// r0 is hardwired and never stored
	always_ff @(posedge clk) begin
		if (regWriteWb && rdWb != '0) begin
			regFile[rdWb] <= writeDataWb;
		end
	end

	// Read ports see a same-cycle writeback value
	assign regDataA = (rsId == '0) ? '0 :
		(regWriteWb && rdWb == rsId) ? writeDataWb : regFile[rsId];
	assign regDataB = (rtId == '0) ? '0 :
		(regWriteWb && rdWb == rtId) ? writeDataWb : regFile[rtId];

	// NVZ register with per-flag enables from execute
	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else begin
			flags <= (flags & ~flagsWe) | (flagsNext & flagsWe);
		end
	end

	// Condition check against the committed flags
	always_comb begin
		condTrue = 1'b0;
		case (condT'(instrId[11:9]))
			CondNe: condTrue = !flags[flagZ];
			CondEq: condTrue = flags[flagZ];
			CondGt: condTrue = !flags[flagZ] && !flags[flagN];
			CondLt: condTrue = flags[flagN];
			CondGe: condTrue = flags[flagZ] || !flags[flagN];
			CondLe: condTrue = flags[flagN] || flags[flagZ];
			CondOv: condTrue = flags[flagV];
			CondAl: condTrue = 1'b1;
			default: condTrue = 1'b0;
		endcase
	end

	// PC+1 plus the signed 9-bit offset, wrapping within imem
	assign offsetExt = {{(dataWidth-9){instrId[8]}}, instrId[8:0]};
	assign targetFull = dataWidth'(pcNextId) + offsetExt;
	assign branchTarget = targetFull[imemAddrWidth-1:0];
	assign branchTaken = (op == OpB) && condTrue;

endmodule

/* hdl/execute.sv */
`timescale 1ns/1ns

module execute (
	input  cpuPkg::opcodeT op,
	input  logic [cpuPkg::dataWidth-1:0] instrEx,
	input  logic [cpuPkg::dataWidth-1:0] regDataA,
	input  logic [cpuPkg::dataWidth-1:0] regDataB,
	input  logic [1:0] forwardA,
	input  logic [1:0] forwardB,
	input  logic [cpuPkg::dataWidth-1:0] aluOutMem,
	input  logic [cpuPkg::dataWidth-1:0] writeDataWb,
	output logic [cpuPkg::dataWidth-1:0] aluOut,
	output logic [cpuPkg::dataWidth-1:0] storeData,
	output logic [cpuPkg::flagWidth-1:0] flagsNext,
	output logic [cpuPkg::flagWidth-1:0] flagsWe
);
	import cpuPkg::*;

	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] sum;
	logic [dataWidth-1:0] diff;
	logic [dataWidth-1:0] memOffset;
	logic [3:0] shamt;
	logic [7:0] imm8;
	logic ovf;

	// Operand source from the register file or a later stage
	function automatic logic [dataWidth-1:0] pickOperand(
		input logic [1:0] sel,
		input logic [dataWidth-1:0] regVal,
		input logic [dataWidth-1:0] memVal,
		input logic [dataWidth-1:0] wbVal
	);
		logic [dataWidth-1:0] val;
		case (sel)
			fwdMem: val = memVal;
			fwdWb: val = wbVal;
			default: val = regVal;
		endcase
		return val;
	endfunction

	always_comb begin
		opA = pickOperand(forwardA, regDataA, aluOutMem, writeDataWb);
		opB = pickOperand(forwardB, regDataB, aluOutMem, writeDataWb);
	end

	// Immediate fields
	assign shamt = instrEx[3:0];
	assign imm8 = instrEx[7:0];
	assign memOffset = {{(dataWidth-4){instrEx[3]}}, instrEx[3:0]};

	assign sum = opA + opB;
	assign diff = opA - opB;

	// sw data register arrives on operand B
	assign storeData = opB;

	always_comb begin
		aluOut = '0;
		ovf = 1'b0;
		flagsWe = '0;
		case (op)
			OpAdd: begin
				aluOut = sum;
				// Like signs in, other sign out
				ovf = (opA[dataWidth-1] == opB[dataWidth-1]) &&
					(sum[dataWidth-1] != opA[dataWidth-1]);
				flagsWe = '1;
			end
			OpSub: begin
				aluOut = diff;
				ovf = (opA[dataWidth-1] != opB[dataWidth-1]) &&
					(diff[dataWidth-1] != opA[dataWidth-1]);
				flagsWe = '1;
			end
			OpXor: begin
				aluOut = opA ^ opB;
				flagsWe[flagZ] = 1'b1;
			end
			OpAnd: begin
				aluOut = opA & opB;
				flagsWe[flagZ] = 1'b1;
			end
			OpOr: begin
				aluOut = opA | opB;
				flagsWe[flagZ] = 1'b1;
			end
			OpSll: begin
				aluOut = opA << shamt;
				flagsWe[flagZ] = 1'b1;
			end
			OpSra: begin
				aluOut = $signed(opA) >>> shamt;
				flagsWe[flagZ] = 1'b1;
			end
			// Word address for memory ops
			OpLw, OpSw: aluOut = opA + memOffset;
			// Byte merge into the old rd value
			OpLlb: aluOut = {opB[15:8], imm8};
			OpLhb: aluOut = {imm8, opB[7:0]};
			default: aluOut = '0;
		endcase
	end

	always_comb begin
		flagsNext = '0;
		flagsNext[flagN] = aluOut[dataWidth-1];
		flagsNext[flagV] = ovf;
		flagsNext[flagZ] = (aluOut == '0);
	end

endmodule

/* hdl/memory.sv */
`timescale 1ns/1ns

module memory (
	input  logic clk,
	input  logic [cpuPkg::dataWidth-1:0] addr,
	input  logic [cpuPkg::dataWidth-1:0] writeData,
	input  logic memWrite,
	output logic [cpuPkg::dataWidth-1:0] readData
);
	import cpuPkg::*;

	logic [dataWidth-1:0] dmem [0:(1 << dmemAddrWidth)-1];
	logic [dmemAddrWidth-1:0] wordAddr;

	// Untouched words read as zero
	initial begin
		for (int i = 0; i < (1 << dmemAddrWidth); i++) begin
			dmem[i] = '0;
		end
	end

	// Upper address bits wrap onto the array
	assign wordAddr = addr[dmemAddrWidth-1:0];

	// Store lands at the clock edge
	always @(posedge clk) begin
		if (memWrite) begin
			dmem[wordAddr] <= writeData;
		end
	end

	// Load data available in the same cycle
	assign readData = dmem[wordAddr];

endmodule

/* hdl/hazardUnit.sv */
`timescale 1ns/1ns

module hazardUnit (
	input  logic [cpuPkg::dataWidth-1:0] instrId,
	input  logic [cpuPkg::regAddrWidth-1:0] rdEx,
	input  logic memReadEx,
	input  logic setsFlagsEx,
	input  logic [cpuPkg::regAddrWidth-1:0] rsEx,
	input  logic [cpuPkg::regAddrWidth-1:0] rtEx,
	input  logic [cpuPkg::regAddrWidth-1:0] rdMem,
	input  logic regWriteMem,
	input  logic [cpuPkg::regAddrWidth-1:0] rdWb,
	input  logic regWriteWb,
	output logic stall,
	output logic [1:0] forwardA,
	output logic [1:0] forwardB
);
	import cpuPkg::*;

	logic [regAddrWidth-1:0] srcA;
	logic [regAddrWidth-1:0] srcB;
	logic loadUse;
	logic flagUse;

	// Sources of the instruction waiting in decode
	assign srcA = regSrcA(instrId);
	assign srcB = regSrcB(instrId);

	// Load result is only ready after the memory stage
	assign loadUse = memReadEx && (rdEx != '0) && ((rdEx == srcA) || (rdEx == srcB));

	// Branch must see flags from the instruction now in execute
	assign flagUse = (opcodeT'(instrId[15:12]) == OpB) && setsFlagsEx;

	assign stall = loadUse || flagUse;

	// Younger result in memory beats the one in writeback
	function automatic logic [1:0] pickForward(
		input logic [regAddrWidth-1:0] src,
		input logic [regAddrWidth-1:0] memRd,
		input logic memWe,
		input logic [regAddrWidth-1:0] wbRd,
		input logic wbWe
	);
		logic [1:0] sel;
		if (memWe && memRd != '0 && memRd == src) begin
			sel = fwdMem;
		end else if (wbWe && wbRd != '0 && wbRd == src) begin
			sel = fwdWb;
		end else begin
			sel = fwdReg;
		end
		return sel;
	endfunction

	always_comb begin
		forwardA = pickForward(rsEx, rdMem, regWriteMem, rdWb, regWriteWb);
		forwardB = pickForward(rtEx, rdMem, regWriteMem, rdWb, regWriteWb);
	end

endmodule

/* hdl/cpu.sv */
`timescale 1ns/1ns

module cpu (
	input  logic clk,
	input  logic rst,
	input  logic imemWe,
	input  logic [cpuPkg::imemAddrWidth-1:0] imemAddr,
	input  logic [cpuPkg::dataWidth-1:0] imemData,
	output logic [cpuPkg::imemAddrWidth-1:0] pc,
	output logic hlt,
	output logic wbEn,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData
);
	import cpuPkg::*;

	// Fetch stage and global control
	logic [dataWidth-1:0] instrIf;
	logic [imemAddrWidth-1:0] pcNextIf;
	logic stall;
	logic halted;
	logic haltPend;

	// Decode stage
	logic [dataWidth-1:0] instrId;
	logic [imemAddrWidth-1:0] pcNextId;
	logic [regAddrWidth-1:0] rsId;
	logic [regAddrWidth-1:0] rtId;
	logic [dataWidth-1:0] regDataA;
	logic [dataWidth-1:0] regDataB;
	opcodeT op;
	logic regWrite, memRead, memWrite, setsFlags, isHalt;
	logic branchTaken;
	logic [imemAddrWidth-1:0] branchTarget;

	// Execute stage
	logic [dataWidth-1:0] instrEx;
	opcodeT opEx;
	logic [regAddrWidth-1:0] rsEx;
	logic [regAddrWidth-1:0] rtEx;
	logic [regAddrWidth-1:0] rdEx;
	logic [dataWidth-1:0] regDataAEx;
	logic [dataWidth-1:0] regDataBEx;
	logic regWriteEx, memReadEx, memWriteEx, setsFlagsEx, haltEx;
	logic [1:0] forwardA;
	logic [1:0] forwardB;
	logic [dataWidth-1:0] aluOut;
	logic [dataWidth-1:0] storeData;
	logic [flagWidth-1:0] flagsNext;
	logic [flagWidth-1:0] flagsWe;

	// Memory stage
	logic [regAddrWidth-1:0] rdMem;
	logic regWriteMem, memReadMem, memWriteMem, haltMem;
	logic [dataWidth-1:0] aluOutMem;
	logic [dataWidth-1:0] storeDataMem;
	logic [dataWidth-1:0] memOutMem;

	// Writeback stage
	logic [regAddrWidth-1:0] rdWb;
	logic regWriteWb, memReadWb, haltWb;
	logic [dataWidth-1:0] aluOutWb;
	logic [dataWidth-1:0] memOutWb;
	logic [dataWidth-1:0] writeDataWb;

	// Fetch stops once hlt is decoded so the PC rests one past it
	assign halted = isHalt || haltPend;

	fetch ifStage (
		.clk(clk), .rst(rst), .stall(stall), .halted(halted),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.pc(pc), .pcNextIf(pcNextIf), .instrIf(instrIf)
	);

	hazardUnit hazard (
		.instrId(instrId), .rdEx(rdEx), .memReadEx(memReadEx), .setsFlagsEx(setsFlagsEx),
		.rsEx(rsEx), .rtEx(rtEx), .rdMem(rdMem), .regWriteMem(regWriteMem),
		.rdWb(rdWb), .regWriteWb(regWriteWb),
		.stall(stall), .forwardA(forwardA), .forwardB(forwardB)
	);

	// IF/ID holds on stall and takes a bubble on redirect or halt
	always_ff @(posedge clk) begin
		if (rst) begin
			instrId <= nopInstr;
		end else if (!stall) begin
			instrId <= (branchTaken || halted) ? nopInstr : instrIf;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pcNextId <= pcNextIf;
		end
	end

	decode idStage (
		.clk(clk), .rst(rst), .instrId(instrId), .pcNextId(pcNextId),
		.regWriteWb(regWriteWb), .rdWb(rdWb), .writeDataWb(writeDataWb),
		.flagsNext(flagsNext), .flagsWe(flagsWe),
		.rsId(rsId), .rtId(rtId), .regDataA(regDataA), .regDataB(regDataB),
		.op(op), .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
		.setsFlags(setsFlags), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.isHalt(isHalt)
	);

	// ID/EX gets a bubble while decode is stalled
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			instrEx <= nopInstr;
			opEx <= opcodeT'(nopInstr[15:12]);
			rsEx <= '0;
			rtEx <= '0;
			regWriteEx <= 1'b0;
			memReadEx <= 1'b0;
			memWriteEx <= 1'b0;
			setsFlagsEx <= 1'b0;
			haltEx <= 1'b0;
		end else begin
			instrEx <= instrId;
			opEx <= op;
			rsEx <= rsId;
			rtEx <= rtId;
			regWriteEx <= regWrite;
			memReadEx <= memRead;
			memWriteEx <= memWrite;
			setsFlagsEx <= setsFlags;
			haltEx <= isHalt;
		end
	end

	always_ff @(posedge clk) begin
		regDataAEx <= regDataA;
		regDataBEx <= regDataB;
	end

	assign rdEx = instrEx[11:8];

	execute exStage (
		.op(opEx), .instrEx(instrEx), .regDataA(regDataAEx), .regDataB(regDataBEx),
		.forwardA(forwardA), .forwardB(forwardB),
		.aluOutMem(aluOutMem), .writeDataWb(writeDataWb),
		.aluOut(aluOut), .storeData(storeData), .flagsNext(flagsNext), .flagsWe(flagsWe)
	);

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst) begin
			rdMem <= '0;
			regWriteMem <= 1'b0;
			memReadMem <= 1'b0;
			memWriteMem <= 1'b0;
			haltMem <= 1'b0;
		end else begin
			rdMem <= rdEx;
			regWriteMem <= regWriteEx;
			memReadMem <= memReadEx;
			memWriteMem <= memWriteEx;
			haltMem <= haltEx;
		end
	end

	always_ff @(posedge clk) begin
		aluOutMem <= aluOut;
		storeDataMem <= storeData;
	end

	memory memStage (
		.clk(clk), .addr(aluOutMem), .writeData(storeDataMem),
		.memWrite(memWriteMem), .readData(memOutMem)
	);

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst) begin
			rdWb <= '0;
			regWriteWb <= 1'b0;
			memReadWb <= 1'b0;
			haltWb <= 1'b0;
		end else begin
			rdWb <= rdMem;
			regWriteWb <= regWriteMem;
			memReadWb <= memReadMem;
			haltWb <= haltMem;
		end
	end

	always_ff @(posedge clk) begin
		aluOutWb <= aluOutMem;
		memOutWb <= memOutMem;
	end

	// Loads retire memory data, everything else the ALU result
	assign writeDataWb = memReadWb ? memOutWb : aluOutWb;

	// Sticky halt state
	always_ff @(posedge clk) begin
		if (rst) begin
			haltPend <= 1'b0;
			hlt <= 1'b0;
		end else begin
			if (isHalt) begin
				haltPend <= 1'b1;
			end
			if (haltWb) begin
				hlt <= 1'b1;
			end
		end
	end

	// Retirement strobe, r0 writes are dropped
	assign wbEn = regWriteWb && (rdWb != '0);
	assign wbReg = rdWb;
	assign wbData = writeDataWb;

endmodule

/* testbench/cpu_asserts.sv */
`timescale 1ns/1ns

module cpu_asserts (
	input logic clk,
	input logic rst,
	input logic [cpuPkg::imemAddrWidth-1:0] pc,
	input logic hlt,
	input logic wbEn,
	input logic [cpuPkg::regAddrWidth-1:0] wbReg
);

	// Halt is sticky until the next reset
	hltSticky: assert property (@(posedge clk) (hlt && !rst) |=> hlt)
		else $error("hlt fell without a reset");

	// Fetch frozen once halted
	pcFrozen: assert property (@(posedge clk) (hlt && !rst) |=> (pc == $past(pc)))
		else $error("pc moved while hlt was high");

	// r0 writes never reach the retirement port
	wbRegNonZero: assert property (@(posedge clk) wbEn |-> (wbReg != '0))
		else $error("wbEn high for register 0");

	// Pipeline is empty right after reset
	wbQuietAfterReset: assert property (@(posedge clk) rst |=> !wbEn)
		else $error("wbEn high in the cycle after reset");

endmodule

bind cpu cpu_asserts asserts (
	.clk(clk), .rst(rst), .pc(pc), .hlt(hlt), .wbEn(wbEn), .wbReg(wbReg)
);

/* testbench/cpuTb.sv */
`timescale 1ns/1ns

module cpuTb;
	import cpuPkg::*;

	// DUT ports
	logic clk;
	logic rst;
	logic imemWe;
	logic [imemAddrWidth-1:0] imemAddr;
	logic [dataWidth-1:0] imemData;
	logic [imemAddrWidth-1:0] pc;
	logic hlt;
	logic wbEn;
	logic [regAddrWidth-1:0] wbReg;
	logic [dataWidth-1:0] wbData;

	// Program under test and the ISA model state
	logic [15:0] prog[$];
	logic [15:0] refRegs [16];
	logic [15:0] refMem [256];
	logic refN, refV, refZ;
	logic refHalted;
	logic [7:0] refHaltPc;
	logic [3:0] expReg[$];
	logic [15:0] expData[$];

	// Compare process state
	logic [3:0] wantReg;
	logic [15:0] wantData;
	logic hltPrev;
	int haltCount = 0;
	int haltTarget;
	int errors = 0;
	time deadline = 0;
	logic [31:0] rngState;

	cpu UUT (
		.clk(clk), .rst(rst), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.pc(pc), .hlt(hlt), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// xorshift32 step
	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Instruction word builders
	function automatic logic [15:0] enc(opcodeT o, int a, int b, int c);
		return {o, 4'(a), 4'(b), 4'(c)};
	endfunction

	function automatic logic [15:0] encByte(opcodeT o, int rd, int imm);
		return {o, 4'(rd), 8'(imm)};
	endfunction

	function automatic logic [15:0] encBr(condT c, int off);
		return {OpB, c, 9'(off)};
	endfunction

	function automatic void emit(logic [15:0] w);
		prog.push_back(w);
	endfunction

	// Architectural register write where r0 stays zero and never retires
	function automatic void retire(int rd, logic [15:0] v);
		if (rd != 0) begin
			refRegs[rd] = v;
			expReg.push_back(4'(rd));
			expData.push_back(v);
		end
	endfunction

	// add and sub update all three flags
	function automatic void setArith(logic [15:0] r, logic ovf);
		refN = r[15];
		refV = ovf;
		refZ = (r == 16'h0000);
	endfunction

	// One instruction of the sequential model returning the next PC
	function automatic int refStep(input int at);
		logic [15:0] w, a, b, r, addr;
		int rd, rs, rt, nxt;
		// Exact signed result before wrapping to 16 bits
		int exact;
		logic take;
		w = prog[at];
		rd = int'(w[11:8]);
		rs = int'(w[7:4]);
		rt = int'(w[3:0]);
		a = refRegs[rs];
		b = refRegs[rt];
		addr = a + {{12{w[3]}}, w[3:0]};
		nxt = at + 1;
		take = 1'b0;
		case (opcodeT'(w[15:12]))
			OpAdd: begin
				r = a + b;
				exact = int'($signed(a)) + int'($signed(b));
				setArith(r, (exact > 32767) || (exact < -32768));
				retire(rd, r);
			end
			OpSub: begin
				r = a - b;
				exact = int'($signed(a)) - int'($signed(b));
				setArith(r, (exact > 32767) || (exact < -32768));
				retire(rd, r);
			end
			// Logic ops and shifts touch only Z
			OpXor, OpAnd, OpOr, OpSll, OpSra: begin
				case (opcodeT'(w[15:12]))
					OpXor: r = a ^ b;
					OpAnd: r = a & b;
					OpOr: r = a | b;
					OpSll: r = a << w[3:0];
					default: r = $signed(a) >>> w[3:0];
				endcase
				refZ = (r == 16'h0000);
				retire(rd, r);
			end
			OpLw: retire(rd, refMem[addr[7:0]]);
			OpSw: refMem[addr[7:0]] = refRegs[rd];
			OpLlb: retire(rd, {refRegs[rd][15:8], w[7:0]});
			OpLhb: retire(rd, {w[7:0], refRegs[rd][7:0]});
			OpB: begin
				case (condT'(w[11:9]))
					CondNe: take = !refZ;
					CondEq: take = refZ;
					CondGt: take = !refZ && !refN;
					CondLt: take = refN;
					CondGe: take = refZ || !refN;
					CondLe: take = refN || refZ;
					CondOv: take = refV;
					default: take = 1'b1;
				endcase
				if (take) begin
					nxt = (at + 1 + int'($signed(w[8:0]))) & 255;
				end
			end
			OpHlt: begin
				refHalted = 1'b1;
				refHaltPc = 8'(at + 1);
				nxt = at;
			end
			default: ;
		endcase
		return nxt;
	endfunction

	// Runs the model over prog and fills the expected retirement queue
	task automatic modelProgram();
		int at;
		int steps;
		expReg.delete();
		expData.delete();
		refN = 1'b0;
		refV = 1'b0;
		refZ = 1'b0;
		refHalted = 1'b0;
		at = 0;
		steps = 0;
		while (!refHalted && steps < 1024) begin
			at = refStep(at);
			steps++;
		end
	endtask

	// Clear all registers, set bytes, then every ALU op
	task automatic buildAluProgram();
		prog.delete();
		for (int r = 1; r < 16; r++) begin
			emit(enc(OpAdd, r, 0, 0));
		end
		emit(encByte(OpLlb, 1, 8'hF0));
		emit(encByte(OpLhb, 1, 8'h7F));
		emit(encByte(OpLlb, 2, 8'h23));
		emit(encByte(OpLhb, 2, 8'h81));
		emit(encByte(OpLlb, 3, 8'hFF));
		emit(enc(OpAdd, 7, 1, 2));
		emit(enc(OpSub, 8, 2, 1));
		emit(enc(OpXor, 9, 1, 2));
		emit(enc(OpAnd, 10, 1, 2));
		emit(enc(OpOr, 11, 1, 3));
		emit(enc(OpSll, 12, 1, 3));
		emit(enc(OpSra, 13, 2, 5));
		emit(enc(OpAdd, 14, 1, 1));
		emit(enc(OpSub, 15, 3, 3));
		emit(enc(OpHlt, 0, 0, 0));
	endtask

	// Dependencies at distance one, two and three
	task automatic buildForwardProgram();
		prog.delete();
		emit(encByte(OpLlb, 1, 8'h21));
		emit(encByte(OpLhb, 1, 8'h43));
		emit(encByte(OpLlb, 2, 8'h65));
		emit(encByte(OpLhb, 2, 8'h87));
		emit(enc(OpAdd, 3, 1, 2));
		emit(enc(OpAdd, 4, 3, 1));
		emit(enc(OpSub, 5, 4, 3));
		emit(enc(OpXor, 6, 5, 4));
		emit(enc(OpAnd, 7, 6, 5));
		emit(enc(OpOr, 8, 7, 7));
		emit(enc(OpSll, 9, 8, 4));
		emit(enc(OpSra, 10, 9, 2));
		emit(enc(OpAdd, 11, 10, 0));
		emit(nopInstr);
		emit(enc(OpAdd, 12, 11, 9));
		// r0 result must not be forwarded
		emit(enc(OpAdd, 0, 12, 12));
		emit(enc(OpAdd, 13, 0, 12));
		emit(enc(OpHlt, 0, 0, 0));
	endtask

	// Store then load, and load-use on every kind of consumer
	task automatic buildMemProgram();
		prog.delete();
		emit(encByte(OpLlb, 1, 8'h34));
		emit(encByte(OpLhb, 1, 8'h12));
		emit(encByte(OpLlb, 2, 8'h40));
		emit(encByte(OpLhb, 2, 8'h00));
		emit(enc(OpSw, 1, 2, 2));
		emit(enc(OpLw, 3, 2, 2));
		emit(enc(OpAdd, 4, 3, 3));
		emit(enc(OpSw, 4, 2, -2));
		emit(enc(OpLw, 5, 2, -2));
		emit(enc(OpSw, 5, 2, 5));
		emit(enc(OpLw, 6, 2, 5));
		emit(enc(OpLw, 7, 6, 0));
		emit(enc(OpSub, 8, 7, 5));
		emit(enc(OpLw, 9, 2, 2));
		emit(encByte(OpLlb, 9, 8'hAA));
		emit(enc(OpHlt, 0, 0, 0));
	endtask

	// Four flag setups times eight conditions with and without a gap
	task automatic buildBranchProgram();
		prog.delete();
		emit(encByte(OpLlb, 1, 8'hFF));
		emit(encByte(OpLhb, 1, 8'h7F));
		emit(encByte(OpLlb, 2, 8'h01));
		emit(encByte(OpLhb, 2, 8'h00));
		for (int s = 0; s < 4; s++) begin
			for (int c = 0; c < 8; c++) begin
				case (s)
					0: emit(enc(OpSub, 4, 1, 1));
					1: emit(enc(OpSub, 4, 2, 1));
					2: emit(enc(OpAdd, 4, 1, 2));
					default: emit(enc(OpSub, 4, 1, 2));
				endcase
				if (c % 2 == 1) begin
					emit(encByte(OpLlb, 7, c));
				end
				emit(encBr(condT'(3'(c)), 1));
				emit(encByte(OpLlb, 5, s * 16 + c));
				emit(encByte(OpLlb, 6, c * 16 + s));
			end
		end
		emit(enc(OpHlt, 0, 0, 0));
	endtask

	// Hazard-dense mix over r0..r4 with forward branches only
	task automatic buildRandomProgram();
		int kind;
		int maxOff;
		int rd, rs, rt;
		prog.delete();
		for (int i = 0; i < 39; i++) begin
			kind = int'(nextRand() % 13);
			rd = int'(nextRand() % 5);
			rs = int'(nextRand() % 5);
			rt = int'(nextRand() % 5);
			maxOff = (38 - i > 3) ? 3 : 38 - i;
			case (kind)
				0, 1, 2, 3, 4: emit(enc(opcodeT'(kind[3:0]), rd, rs, rt));
				5, 6: emit(enc(opcodeT'(kind[3:0]), rd, rs, int'(nextRand() % 16)));
				7: emit(enc(OpLw, rd, rs, int'(nextRand() % 16)));
				8: emit(enc(OpSw, rd, rs, int'(nextRand() % 16)));
				9: emit(encByte(OpLlb, rd, int'(nextRand() % 256)));
				10: emit(encByte(OpLhb, rd, int'(nextRand() % 256)));
				11: emit(encBr(condT'(3'(nextRand())), int'(nextRand() % (maxOff + 1))));
				default: emit(nopInstr);
			endcase
		end
		emit(enc(OpHlt, 0, 0, 0));
	endtask

	// Reset, load, run the model, release and wait for hlt
	task automatic runProgram();
		@(negedge clk);
		deadline = $time + 10 * (2 + prog.size() + 3 * prog.size() + 10);
		rst = 1'b1;
		repeat (2) @(negedge clk);
		for (int i = 0; i < prog.size(); i++) begin
			imemWe = 1'b1;
			imemAddr = 8'(i);
			imemData = prog[i];
			@(negedge clk);
		end
		imemWe = 1'b0;
		modelProgram();
		haltTarget = haltCount + 1;
		rst = 1'b0;
		wait (haltCount == haltTarget);
		// A few idle cycles so pc is seen holding
		repeat (3) @(negedge clk);
	endtask

	// Retirement and halt checks on the rising edge
	always @(posedge clk) begin
		if (!rst && wbEn) begin
			assert (expReg.size() > 0) else begin
				errors++;
				$display("Write to r%0d retired when no write was expected", wbReg);
			end
			if (expReg.size() > 0) begin
				wantReg = expReg.pop_front();
				wantData = expData.pop_front();
				assert (wbReg == wantReg) else begin
					errors++;
					$display("ERROR wbReg: got %h expected %h", wbReg, wantReg);
				end
				assert (wbData == wantData) else begin
					errors++;
					$display("ERROR wbData: got %h expected %h", wbData, wantData);
				end
			end
		end
		if (!rst && hlt) begin
			// Frozen one past the halt word for as long as hlt stays up
			assert (pc == refHaltPc) else begin
				errors++;
				$display("ERROR pc: got %h expected %h", pc, refHaltPc);
			end
			if (!hltPrev) begin
				assert (expReg.size() == 0) else begin
					errors++;
					$display("Halted with %0d expected register writes missing", expReg.size());
				end
				haltCount++;
			end
		end
		hltPrev = hlt;
	end

	// Watchdog against a core that never halts
	initial begin
		@(posedge clk);
		while (deadline == 0 || $time <= deadline) begin
			@(posedge clk);
		end
		errors++;
		$display("Timeout: the core did not halt within its cycle budget");
		$display("Errors: %0d", errors);
		$display("Checks failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		hltPrev = 1'b0;
		rngState = 32'd90757;
		// Model memory matches the zeroed data array
		for (int i = 0; i < 256; i++) begin
			refMem[i] = 16'h0000;
		end
		for (int i = 0; i < 16; i++) begin
			refRegs[i] = 16'h0000;
		end
		buildAluProgram();
		runProgram();
		buildForwardProgram();
		runProgram();
		buildMemProgram();
		runProgram();
		buildBranchProgram();
		runProgram();
		for (int n = 0; n < 10; n++) begin
			buildRandomProgram();
			runProgram();
		end
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* compile.f */
hdl/cpuPkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/hazardUnit.sv
hdl/cpu.sv
testbench/cpu_asserts.sv
testbench/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpuTb
LOG ?= sim.log
FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Checks failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
